//--- logic/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath width.
`define XLEN 32

// Memory sizes in 32-bit words.
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// First fetch address out of reset.
`define RESET_PC 32'h0000_0000

`endif

//--- logic/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_t;

    // Operand source for the E stage.
    typedef enum logic [1:0] {
        FWD_REG   = 2'd0,
        FWD_M_ALU = 2'd1,
        FWD_M_WB  = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } fd_bundle_t;

    typedef struct packed {
        logic             valid;
        logic             reg_write;
        result_src_t      result_src;
        logic             mem_write;
        logic             jump;
        logic             branch;
        logic             jalr;
        alu_op_t          alu_ctrl;
        logic             alu_src;
        logic [2:0]       funct3;
        logic             rs1_used;
        logic             rs2_used;
        logic [`XLEN-1:0] rd1;
        logic [`XLEN-1:0] rd2;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] pc_plus4;
        logic [`XLEN-1:0] imm_ext;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
    } de_bundle_t;

    typedef struct packed {
        logic             valid;
        logic             reg_write;
        result_src_t      result_src;
        logic [4:0]       rd;
        logic [`XLEN-1:0] alu_result;
        logic [`XLEN-1:0] pc_plus4;
    } em_bundle_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } wb_t;

endpackage

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module fetch_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           run,
    input  logic                           hold,
    input  logic                           redirect,
    input  logic [`XLEN-1:0]               redirect_pc,
    input  logic                           imem_we,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                    imem_wdata,
    output rv_pkg::fd_bundle_t             fd
);
    localparam int IAW = $clog2(`IMEM_DEPTH);

    logic [31:0]      imem [`IMEM_DEPTH];
    logic [`XLEN-1:0] pc;

    // Program load port.
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // The RAM read is the F/D register, so fetch takes one cycle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RESET_PC;
            fd <= '0;
        end else if (!run) begin
            pc <= `RESET_PC;
            fd <= '0;
        end else if (redirect) begin
            pc       <= redirect_pc;
            fd.valid <= 1'b0;
        end else if (!hold) begin
            pc       <= pc + 32'd4;
            fd.valid <= 1'b1;
            fd.pc    <= pc;
            fd.instr <= imem[pc[IAW+1:2]];
        end
    end

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::fd_bundle_t fd,
    input  rv_pkg::wb_t        wb,
    output rv_pkg::de_bundle_t de
);
    import rv_pkg::*;

    logic [`XLEN-1:0] regs [32];
    logic [`XLEN-1:0] rd1;
    logic [`XLEN-1:0] rd2;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sub_sra,
                                           input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && sub_sra) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Same-cycle write passes straight to the read.
    assign rs1 = fd.instr[19:15];
    assign rs2 = fd.instr[24:20];
    assign rd1 = (rs1 == 5'd0) ? '0 : (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

    assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign imm_s = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
    assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                    fd.instr[11:8], 1'b0};
    assign imm_u = {fd.instr[31:12], 12'b0};
    assign imm_j = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12], fd.instr[20],
                    fd.instr[30:21], 1'b0};

    always_comb begin
        de            = '0;
        de.valid      = fd.valid;
        de.pc         = fd.pc;
        de.pc_plus4   = fd.pc + 32'd4;
        de.funct3     = fd.instr[14:12];
        de.rd         = fd.instr[11:7];
        de.rs1        = rs1;
        de.rs2        = rs2;
        de.rd1        = rd1;
        de.rd2        = rd2;
        de.alu_ctrl   = ALU_ADD;
        de.result_src = RES_ALU;
        if (fd.valid) begin
            case (fd.instr[6:0])
                OP_LUI: begin
                    de.reg_write = 1'b1;
                    de.alu_src   = 1'b1;
                    de.alu_ctrl  = ALU_PASS_B;
                    de.imm_ext   = imm_u;
                end
                OP_AUIPC: begin
                    // Target folded into the immediate.
                    de.reg_write = 1'b1;
                    de.alu_src   = 1'b1;
                    de.alu_ctrl  = ALU_PASS_B;
                    de.imm_ext   = fd.pc + imm_u;
                end
                OP_JAL: begin
                    de.reg_write  = 1'b1;
                    de.result_src = RES_PC4;
                    de.jump       = 1'b1;
                    de.imm_ext    = imm_j;
                end
                OP_JALR: begin
                    de.reg_write  = 1'b1;
                    de.result_src = RES_PC4;
                    de.jump       = 1'b1;
                    de.jalr       = 1'b1;
                    de.alu_src    = 1'b1;
                    de.rs1_used   = 1'b1;
                    de.imm_ext    = imm_i;
                end
                OP_BRANCH: begin
                    de.branch   = 1'b1;
                    de.rs1_used = 1'b1;
                    de.rs2_used = 1'b1;
                    de.imm_ext  = imm_b;
                end
                OP_LOAD: begin
                    de.reg_write  = 1'b1;
                    de.result_src = RES_MEM;
                    de.alu_src    = 1'b1;
                    de.rs1_used   = 1'b1;
                    de.imm_ext    = imm_i;
                end
                OP_STORE: begin
                    de.mem_write = 1'b1;
                    de.alu_src   = 1'b1;
                    de.rs1_used  = 1'b1;
                    de.rs2_used  = 1'b1;
                    de.imm_ext   = imm_s;
                end
                OP_IMM: begin
                    de.reg_write = 1'b1;
                    de.alu_src   = 1'b1;
                    de.rs1_used  = 1'b1;
                    de.alu_ctrl  = alu_decode(fd.instr[14:12], fd.instr[30], 1'b0);
                    de.imm_ext   = imm_i;
                end
                OP_REG: begin
                    de.reg_write = 1'b1;
                    de.rs1_used  = 1'b1;
                    de.rs2_used  = 1'b1;
                    de.alu_ctrl  = alu_decode(fd.instr[14:12], fd.instr[30], 1'b1);
                end
                default: begin
                    de.valid = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- logic/de_reg.sv
`timescale 1ns/1ps

module de_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall,
    input  logic               flush,
    input  rv_pkg::de_bundle_t de_d,
    output rv_pkg::de_bundle_t de_e
);

    // A flush discards the D instruction, a stall leaves it in D.
    // Either way E gets an all-zero bubble.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_e <= '0;
        end else if (flush) begin
            de_e <= '0;
        end else if (stall) begin
            de_e <= '0;
        end else begin
            de_e <= de_d;
        end
    end

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module execute_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  rv_pkg::de_bundle_t             de_e,
    input  rv_pkg::fwd_sel_t               fwd_a,
    input  rv_pkg::fwd_sel_t               fwd_b,
    input  logic [`XLEN-1:0]               m_wb_data,
    output rv_pkg::em_bundle_t             em,
    output logic                           dmem_we,
    output logic [$clog2(`DMEM_DEPTH)-1:0] dmem_addr,
    output logic [`XLEN-1:0]               dmem_wdata,
    output logic                           redirect,
    output logic [`XLEN-1:0]               redirect_pc
);
    import rv_pkg::*;

    localparam int DAW = $clog2(`DMEM_DEPTH);

    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b_reg;
    logic [`XLEN-1:0] src_b;
    logic [`XLEN-1:0] alu_result;
    logic             take_branch;

    always_comb begin
        case (fwd_a)
            FWD_M_ALU: src_a = em.alu_result;
            FWD_M_WB:  src_a = m_wb_data;
            default:   src_a = de_e.rd1;
        endcase
        case (fwd_b)
            FWD_M_ALU: src_b_reg = em.alu_result;
            FWD_M_WB:  src_b_reg = m_wb_data;
            default:   src_b_reg = de_e.rd2;
        endcase
    end

    assign src_b = de_e.alu_src ? de_e.imm_ext : src_b_reg;

    always_comb begin
        case (de_e.alu_ctrl)
            ALU_ADD:    alu_result = src_a + src_b;
            ALU_SUB:    alu_result = src_a - src_b;
            ALU_AND:    alu_result = src_a & src_b;
            ALU_OR:     alu_result = src_a | src_b;
            ALU_XOR:    alu_result = src_a ^ src_b;
            ALU_SLL:    alu_result = src_a << src_b[4:0];
            ALU_SRL:    alu_result = src_a >> src_b[4:0];
            ALU_SRA:    alu_result = $signed(src_a) >>> src_b[4:0];
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, src_a < src_b};
            ALU_PASS_B: alu_result = src_b;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        case (de_e.funct3)
            3'b000:  take_branch = (src_a == src_b_reg);
            3'b001:  take_branch = (src_a != src_b_reg);
            3'b100:  take_branch = ($signed(src_a) < $signed(src_b_reg));
            3'b101:  take_branch = ($signed(src_a) >= $signed(src_b_reg));
            3'b110:  take_branch = (src_a < src_b_reg);
            3'b111:  take_branch = (src_a >= src_b_reg);
            default: take_branch = 1'b0;
        endcase
    end

    // JALR target comes from the ALU sum with bit 0 cleared.
    assign redirect    = de_e.valid && (de_e.jump || (de_e.branch && take_branch));
    assign redirect_pc = de_e.jalr ? {alu_result[`XLEN-1:1], 1'b0} : de_e.pc + de_e.imm_ext;

    // Store issues from E. The load read address shares the port.
    assign dmem_we    = de_e.valid && de_e.mem_write;
    assign dmem_addr  = alu_result[DAW+1:2];
    assign dmem_wdata = src_b_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            em <= '0;
        end else begin
            em.valid      <= de_e.valid;
            em.reg_write  <= de_e.reg_write;
            em.result_src <= de_e.result_src;
            em.rd         <= de_e.rd;
            em.alu_result <= alu_result;
            em.pc_plus4   <= de_e.pc_plus4;
        end
    end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::fd_bundle_t fd,
    input  rv_pkg::de_bundle_t de_e,
    input  rv_pkg::em_bundle_t em,
    output rv_pkg::fwd_sel_t   fwd_a,
    output rv_pkg::fwd_sel_t   fwd_b,
    output logic               load_stall
);
    import rv_pkg::*;

    logic [6:0] d_opcode;
    logic [4:0] d_rs1;
    logic [4:0] d_rs2;
    logic       d_rs1_used;
    logic       d_rs2_used;
    logic       e_is_load;

    function automatic fwd_sel_t fwd_pick(input logic used, input logic [4:0] rs,
                                          input em_bundle_t m);
        if (!used || !m.valid || !m.reg_write || m.rd == 5'd0 || m.rd != rs) begin
            return FWD_REG;
        end
        // ALU results skip the writeback mux.
        return (m.result_src == RES_ALU) ? FWD_M_ALU : FWD_M_WB;
    endfunction

    assign fwd_a = fwd_pick(de_e.rs1_used, de_e.rs1, em);
    assign fwd_b = fwd_pick(de_e.rs2_used, de_e.rs2, em);

    assign d_opcode   = fd.instr[6:0];
    assign d_rs1      = fd.instr[19:15];
    assign d_rs2      = fd.instr[24:20];
    assign d_rs1_used = fd.valid && !(d_opcode inside {OP_LUI, OP_AUIPC, OP_JAL});
    assign d_rs2_used = fd.valid && (d_opcode inside {OP_BRANCH, OP_STORE, OP_REG});

    assign e_is_load  = de_e.valid && de_e.reg_write && de_e.result_src == RES_MEM &&
                        de_e.rd != 5'd0;
    assign load_stall = e_is_load && ((d_rs1_used && d_rs1 == de_e.rd) ||
                                      (d_rs2_used && d_rs2 == de_e.rd));

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module data_ram (
    input  logic                           clk,
    input  logic                           we,
    input  logic [$clog2(`DMEM_DEPTH)-1:0] addr,
    input  logic [`XLEN-1:0]               wdata,
    output logic [`XLEN-1:0]               rdata
);

    logic [`XLEN-1:0] mem [`DMEM_DEPTH];

    // Read returns the old word on a same-address write.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           run,
    input  logic                           imem_we,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr,
    input  logic [31:0]                    imem_wdata,
    output rv_pkg::wb_t                    retire
);
    import rv_pkg::*;

    localparam int DAW = $clog2(`DMEM_DEPTH);

    fd_bundle_t       fd;
    de_bundle_t       de_d;
    de_bundle_t       de_e;
    em_bundle_t       em;
    wb_t              wb;
    fwd_sel_t         fwd_a;
    fwd_sel_t         fwd_b;
    logic             load_stall;
    logic             redirect;
    logic [`XLEN-1:0] redirect_pc;
    logic             dmem_we;
    logic [DAW-1:0]   dmem_addr;
    logic [`XLEN-1:0] dmem_wdata;
    logic [`XLEN-1:0] dmem_rdata;
    logic [`XLEN-1:0] m_wb_data;

    fetch_unit fetch0 (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .hold        (load_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .fd          (fd)
    );

    decode_stage decode0 (
        .clk (clk),
        .rst (rst),
        .fd  (fd),
        .wb  (wb),
        .de  (de_d)
    );

    de_reg de_reg0 (
        .clk   (clk),
        .rst   (rst),
        .stall (load_stall),
        .flush (redirect),
        .de_d  (de_d),
        .de_e  (de_e)
    );

    execute_unit execute0 (
        .clk         (clk),
        .rst         (rst),
        .de_e        (de_e),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .m_wb_data   (m_wb_data),
        .em          (em),
        .dmem_we     (dmem_we),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    hazard_unit hazard0 (
        .fd         (fd),
        .de_e       (de_e),
        .em         (em),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .load_stall (load_stall)
    );

    data_ram dmem0 (
        .clk   (clk),
        .we    (dmem_we),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .rdata (dmem_rdata)
    );

    // M-stage result select and writeback.
    always_comb begin
        case (em.result_src)
            RES_MEM: m_wb_data = dmem_rdata;
            RES_PC4: m_wb_data = em.pc_plus4;
            default: m_wb_data = em.alu_result;
        endcase
        wb.valid = em.valid && em.reg_write && (em.rd != 5'd0);
        wb.rd    = em.rd;
        wb.data  = m_wb_data;
    end

    assign retire = wb;

endmodule

//--- verification/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
    input logic               clk,
    input logic               rst,
    input logic               stall,
    input logic               flush,
    input rv_pkg::de_bundle_t de_e
);

    // Stall or flush leaves a bubble in E.
    bubble_after_clear: assert property (
        @(posedge clk) disable iff (rst)
        (stall || flush) |=> (!de_e.valid && !de_e.reg_write)
    ) else $error("E stage not cleared after stall or flush");

    reset_clears_valid: assert property (
        @(posedge clk) rst |=> !de_e.valid
    ) else $error("E stage valid after reset");

    no_bubble_store: assert property (
        @(posedge clk) disable iff (rst)
        !de_e.valid |-> !de_e.mem_write
    ) else $error("Bubble in E carries a memory write");

endmodule

bind de_reg rv_core_assertions asrt0 (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .flush (flush),
    .de_e  (de_e)
);

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb;
    import rv_pkg::*;

    localparam int IAW            = $clog2(`IMEM_DEPTH);
    localparam int GOLDEN_WORDS   = 256;
    localparam int RESET_TIMEOUT  = 20;
    localparam int RETIRE_TIMEOUT = 100;
    localparam int QUIET_CYCLES   = 50;

    logic           clk;
    logic           rst;
    logic           run;
    logic           imem_we;
    logic [IAW-1:0] imem_addr;
    logic [31:0]    imem_wdata;
    wb_t            retire;

    // Program size, program, retire count, then rd/data pairs.
    logic [31:0] golden [GOLDEN_WORDS];
    int          prog_len;
    int          retire_len;
    int          retire_base;

    rv_core dut0 (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .retire     (retire)
    );

    always #5 clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Instruction RAM is written through the load port while run is low.
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= IAW'(i);
            imem_wdata <= golden[1 + i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst) begin
            @(posedge clk);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                $display("Timeout: reset was never released.");
                stop_with_failure();
            end
        end
    endtask

    task automatic wait_retire();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > RETIRE_TIMEOUT) begin
                $display("Timeout: no retire event within %0d cycles.", RETIRE_TIMEOUT);
                stop_with_failure();
            end
        end while (!retire.valid);
    endtask

    task automatic check_retire_trace();
        for (int n = 0; n < retire_len; n++) begin
            wait_retire();
            check_equal($sformatf("retire[%0d].rd", n), 32'(retire.rd),
                        golden[retire_base + 2 * n]);
            check_equal($sformatf("retire[%0d].data", n), retire.data,
                        golden[retire_base + 2 * n + 1]);
        end
    endtask

    // Terminal self-loop writes x0 only.
    task automatic expect_quiet();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            check_equal("retire.valid", 32'(retire.valid), 32'd0);
        end
    endtask

    initial begin
        clk        = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;

        $readmemh("verification/rv_golden.txt", golden);
        prog_len    = int'(golden[0]);
        retire_base = prog_len + 2;
        if (prog_len < 1 || prog_len > `IMEM_DEPTH || retire_base >= GOLDEN_WORDS) begin
            $display("Golden file holds no valid program size.");
            stop_with_failure();
        end
        retire_len = int'(golden[prog_len + 1]);
        if (retire_len < 1 || retire_base + 2 * retire_len > GOLDEN_WORDS) begin
            $display("Golden file holds no valid retire count.");
            stop_with_failure();
        end

        load_program();
        wait_reset_release();

        // Idle core with run low.
        @(negedge clk);
        check_equal("retire.valid", 32'(retire.valid), 32'd0);
        check_equal("redirect", 32'(dut0.redirect), 32'd0);
        check_equal("pc", dut0.fetch0.pc, `RESET_PC);

        @(posedge clk);
        run <= 1'b1;

        check_retire_trace();
        expect_quiet();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- verification/rv_golden.txt
// Program word count, program words, retire count,
// then one rd and data pair per expected retire event, all hex.
17
00500093 // 00: addi  x1, x0, 5
00708113 // 04: addi  x2, x1, 7
002081B3 // 08: add   x3, x1, x2
40118233 // 0c: sub   x4, x3, x1
00421293 // 10: slli  x5, x4, 4
0032C333 // 14: xor   x6, x5, x3
123453B7 // 18: lui   x7, 0x12345
00602423 // 1c: sw    x6, 8(x0)
00802403 // 20: lw    x8, 8(x0)
00140493 // 24: addi  x9, x8, 1
00648463 // 28: beq   x9, x6, +8
00649463 // 2c: bne   x9, x6, +8
06300513 // 30: addi  x10, x0, 99
008005EF // 34: jal   x11, +8
04D00513 // 38: addi  x10, x0, 77
00000617 // 3c: auipc x12, 0
00C606E7 // 40: jalr  x13, 12(x12)
03700513 // 44: addi  x10, x0, 55
00100013 // 48: addi  x0, x0, 1
FFF00713 // 4c: addi  x14, x0, -1
01C75793 // 50: srli  x15, x14, 28
00F72833 // 54: slt   x16, x14, x15
0000006F // 58: jal   x0, 0
0F
01 00000005
02 0000000C
03 00000011
04 0000000C
05 000000C0
06 000000D1
07 12345000
08 000000D1
09 000000D2
0B 00000038
0C 0000003C
0D 00000044
0E FFFFFFFF
0F 0000000F
10 00000001

//--- project.f
+incdir+logic
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/de_reg.sv
logic/execute_unit.sv
logic/hazard_unit.sv
logic/data_ram.sv
logic/rv_core.sv
verification/rv_core_assertions.sv
verification/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
